// File: files.f
src/vision_pkg.sv
src/ctrl_pkg.sv
src/conv_filter.sv
src/edge_map_ram.sv
src/stripe_detector.sv
src/apb_regs.sv
src/pattern_recognition.sv
tb/pattern_recognition_assert.sv
tb/tb_pattern_recognition.sv

// File: run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_pattern_recognition \
    -f files.f --Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/sim +verilator+error+limit+1000)
rc=$?
echo "$out"
if [ $rc -ne 0 ]; then
    echo "simulator exited with status $rc"
    exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

// File: src/apb_regs.sv
module apb_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  ctrl_pkg::apb_req_t  apb_req,
    output ctrl_pkg::apb_rsp_t  apb_rsp,
    output ctrl_pkg::det_cfg_t  cfg,
    output logic                capture_cmd,
    output logic                clear_cmd,
    input  logic [7:0]          stripe_count,
    input  logic                crossing,
    input  logic                det_done
);
    import ctrl_pkg::*;

    logic        access;
    logic        wr;
    logic        addr_ok;
    logic        done_q;
    logic [31:0] rdata;
    reg_addr_e   addr;
    cmd_e        cmd;
    det_cfg_t    cfg_q;

    // Access phase only, no wait states
    assign access = apb_req.psel && apb_req.penable;
    assign wr     = access && apb_req.pwrite;
    assign addr   = reg_addr_e'(apb_req.paddr);
    assign cmd    = cmd_e'(apb_req.pwdata[1:0]);

    // ==================================================================
    // Read mux and decode
    // ==================================================================

    always_comb begin
        addr_ok = 1'b1;
        rdata   = '0;
        case (addr)
            KERN0:       rdata = {8'h00, cfg_q.kernel[2:0]};
            KERN1:       rdata = {8'h00, cfg_q.kernel[5:3]};
            KERN2:       rdata = {8'h00, cfg_q.kernel[8:6]};
            THRESH:      rdata = {24'h0, cfg_q.threshold};
            MIN_STRIPES: rdata = {24'h0, cfg_q.min_stripes};
            // Commands self clear and read as zero
            CMD:         rdata = '0;
            STATUS:      rdata = {16'h0, stripe_count, 6'h0, crossing, done_q};
            default:     addr_ok = 1'b0;
        endcase
        if (!access || apb_req.pwrite) begin
            rdata = '0;
        end
    end

    // STATUS is read only
    assign apb_rsp = '{
        prdata:  rdata,
        pready:  1'b1,
        pslverr: access && (!addr_ok || (apb_req.pwrite && addr == STATUS))
    };

    // ==================================================================
    // Register writes and command pulses
    // ==================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_q       <= cfg_rst;
            capture_cmd <= 1'b0;
            clear_cmd   <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            capture_cmd <= wr && (addr == CMD) && (cmd == CAPTURE);
            clear_cmd   <= wr && (addr == CMD) && (cmd == CLEAR);
            if (wr) begin
                case (addr)
                    KERN0:       cfg_q.kernel[2:0]  <= apb_req.pwdata[23:0];
                    KERN1:       cfg_q.kernel[5:3]  <= apb_req.pwdata[23:0];
                    KERN2:       cfg_q.kernel[8:6]  <= apb_req.pwdata[23:0];
                    THRESH:      cfg_q.threshold    <= apb_req.pwdata[7:0];
                    MIN_STRIPES: cfg_q.min_stripes  <= apb_req.pwdata[7:0];
                    default:     ;
                endcase
            end
            // Sticky done, a new result beats a pending clear
            if (det_done) begin
                done_q <= 1'b1;
            end else if (clear_cmd) begin
                done_q <= 1'b0;
            end
        end
    end

    assign cfg = cfg_q;

endmodule

// File: src/conv_filter.sv
module conv_filter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  vision_pkg::pix_beat_t  pix_in,
    input  logic                   pix_valid,
    output logic                   pix_ready,
    input  vision_pkg::kernel_t    kernel,
    output vision_pkg::edge_beat_t edge_out,
    output logic                   edge_valid,
    input  logic                   edge_ready
);
    import vision_pkg::*;

    // Raster position of the accepted pixel
    logic [col_w-1:0] col_q;
    logic [col_w-1:0] cur_col;
    logic [row_w-1:0] row_q;
    logic [row_w-1:0] cur_row;

    // Line buffers, mid holds row r-1 and top holds row r-2
    pix_t lb_mid [img_w];
    pix_t lb_top [img_w];

    // Two older window columns, index [row][col], col 0 oldest
    pix_t win_q [3][2];
    // Full 3x3 window including the incoming column
    pix_t taps [3][3];

    logic               accept;
    logic               win_ok;
    logic               first_win;
    logic signed [20:0] acc;
    logic [20:0]        mag_abs;
    pix_t               mag_sat;

    // Single output slot
    logic       out_valid_q;
    edge_beat_t out_q;

    // Stall only when the slot is full and cannot drain this cycle
    assign pix_ready = !out_valid_q || edge_ready;
    assign accept    = pix_valid && pix_ready;

    // sof forces the pixel to (0,0)
    assign cur_col = pix_in.sof ? '0 : col_q;
    assign cur_row = pix_in.sof ? '0 : row_q;

    assign win_ok    = (cur_row >= row_w'(2)) && (cur_col >= col_w'(2));
    assign first_win = (cur_row == row_w'(2)) && (cur_col == col_w'(2));

    // ==================================================================
    // Window and sum of products
    // ==================================================================

    always_comb begin
        for (int r = 0; r < 3; r++) begin
            taps[r][0] = win_q[r][0];
            taps[r][1] = win_q[r][1];
        end
        // Newest column comes straight from buffers and input
        taps[0][2] = lb_top[cur_col];
        taps[1][2] = lb_mid[cur_col];
        taps[2][2] = pix_in.data;
    end

    always_comb begin
        acc = '0;
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                // Pixel zero extended into a signed product
                acc = acc + 21'($signed({1'b0, taps[r][c]}) * kernel[3*r+c]);
            end
        end
    end

    // Absolute value, clipped to the pixel range
    assign mag_abs = acc[20] ? 21'(-acc) : 21'(acc);
    assign mag_sat = (mag_abs > 21'd255) ? 8'hFF : mag_abs[7:0];

    // ==================================================================
    // Storage
    // ==================================================================

    always_ff @(posedge clk) begin
        if (accept) begin
            // Shift the column down through the line buffers
            lb_top[cur_col] <= lb_mid[cur_col];
            lb_mid[cur_col] <= pix_in.data;
            for (int r = 0; r < 3; r++) begin
                win_q[r][0] <= win_q[r][1];
                win_q[r][1] <= taps[r][2];
            end
        end
        if (accept && win_ok) begin
            out_q.mag <= mag_sat;
            out_q.sof <= first_win;
        end
    end

    // Raster counters and slot state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_q       <= '0;
            row_q       <= '0;
            out_valid_q <= 1'b0;
        end else begin
            if (accept) begin
                if (cur_col == col_w'(img_w - 1)) begin
                    col_q <= '0;
                    row_q <= (cur_row == row_w'(img_h - 1)) ? '0 : cur_row + 1'b1;
                end else begin
                    col_q <= cur_col + 1'b1;
                    row_q <= cur_row;
                end
            end
            // Refill wins over drain in the same cycle
            if (accept && win_ok) begin
                out_valid_q <= 1'b1;
            end else if (edge_ready) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    assign edge_out   = out_q;
    assign edge_valid = out_valid_q;

endmodule

// File: src/ctrl_pkg.sv
package ctrl_pkg;

    // ==================================================================
    // APB bus
    // ==================================================================

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // Register offsets
    // KERN words carry three coefficients in bits 23:0
    typedef enum logic [7:0] {
        KERN0       = 8'h00,
        KERN1       = 8'h04,
        KERN2       = 8'h08,
        THRESH      = 8'h0C,
        MIN_STRIPES = 8'h10,
        CMD         = 8'h14,
        STATUS      = 8'h18
    } reg_addr_e;

    // Opcodes written to CMD bits 1:0
    typedef enum logic [1:0] {
        NOP     = 2'd0,
        CAPTURE = 2'd1,
        CLEAR   = 2'd2
    } cmd_e;

    // ==================================================================
    // Controller states and configuration
    // ==================================================================

    typedef enum logic [1:0] {CAP_IDLE, CAP_ARMED, CAP_FILL, CAP_FULL} cap_state_e;
    typedef enum logic [1:0] {DET_IDLE, DET_ADDR, DET_SCAN, DET_DONE} det_state_e;

    typedef struct packed {
        vision_pkg::kernel_t kernel;
        vision_pkg::pix_t    threshold;
        logic [7:0]          min_stripes;
    } det_cfg_t;

    // Register values after reset
    localparam det_cfg_t cfg_rst = '{kernel: '0, threshold: '0, min_stripes: 8'd3};

endpackage

// File: src/edge_map_ram.sv
module edge_map_ram (
    input  logic                          clk,
    input  logic                          rst_n,
    input  vision_pkg::edge_beat_t        edge_beat,
    input  logic                          beat_fire,
    input  vision_pkg::pix_t              threshold,
    input  logic                          capture_cmd,
    input  logic                          clear_cmd,
    output logic                          map_full,
    input  logic [vision_pkg::map_aw-1:0] map_addr,
    output logic                          map_bit
);
    import vision_pkg::*;
    import ctrl_pkg::*;

    cap_state_e        state_q;
    logic [map_aw-1:0] wr_ptr_q;
    logic              mem_q [map_depth];
    logic              wr_en;
    logic              last_wr;
    logic              edge_bit;

    // Binary edge decision
    assign edge_bit = edge_beat.mag >= threshold;

    // Capture starts on a frame boundary and then takes every beat
    assign wr_en = beat_fire &&
                   ((state_q == CAP_ARMED && edge_beat.sof) || state_q == CAP_FILL);
    assign last_wr = wr_en && (wr_ptr_q == map_aw'(map_depth - 1));

    // ==================================================================
    // Capture FSM
    // ==================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= CAP_IDLE;
            wr_ptr_q <= '0;
        end else if (clear_cmd) begin
            state_q <= CAP_IDLE;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            case (state_q)
                CAP_IDLE: begin
                    if (capture_cmd) begin
                        state_q  <= CAP_ARMED;
                        wr_ptr_q <= '0;
                    end
                end
                // sof beat lands at address 0
                CAP_ARMED: if (wr_en) state_q <= CAP_FILL;
                CAP_FILL:  if (last_wr) state_q <= CAP_FULL;
                // Held until CLEAR
                default:   state_q <= CAP_FULL;
            endcase
        end
    end

    assign map_full = (state_q == CAP_FULL);

    // Bit memory, one write and one registered read
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_q[wr_ptr_q] <= edge_bit;
        end
        map_bit <= mem_q[map_addr];
    end

endmodule

// File: src/pattern_recognition.sv
module pattern_recognition (
    input  logic                   clk,
    input  logic                   rst_n,
    input  vision_pkg::pix_beat_t  pix_in,
    input  logic                   pix_valid,
    output logic                   pix_ready,
    output vision_pkg::edge_beat_t edge_out,
    output logic                   edge_valid,
    input  logic                   edge_ready,
    input  ctrl_pkg::apb_req_t     apb_req,
    output ctrl_pkg::apb_rsp_t     apb_rsp,
    output logic                   det_done
);
    import vision_pkg::*;
    import ctrl_pkg::*;

    det_cfg_t          cfg;
    logic              capture_cmd;
    logic              clear_cmd;
    logic              beat_fire;
    logic              map_full;
    logic              map_bit;
    logic              crossing;
    logic [map_aw-1:0] map_addr;
    logic [7:0]        stripe_count;

    // Capture follows the beats that actually leave the chip
    assign beat_fire = edge_valid && edge_ready;

    // ==================================================================
    // Datapath
    // ==================================================================

    conv_filter u_conv_filter (
        .clk        (clk),
        .rst_n      (rst_n),
        .pix_in     (pix_in),
        .pix_valid  (pix_valid),
        .pix_ready  (pix_ready),
        .kernel     (cfg.kernel),
        .edge_out   (edge_out),
        .edge_valid (edge_valid),
        .edge_ready (edge_ready)
    );

    edge_map_ram u_edge_map_ram (
        .clk         (clk),
        .rst_n       (rst_n),
        .edge_beat   (edge_out),
        .beat_fire   (beat_fire),
        .threshold   (cfg.threshold),
        .capture_cmd (capture_cmd),
        .clear_cmd   (clear_cmd),
        .map_full    (map_full),
        .map_addr    (map_addr),
        .map_bit     (map_bit)
    );

    stripe_detector u_stripe_detector (
        .clk          (clk),
        .rst_n        (rst_n),
        .map_full     (map_full),
        .map_addr     (map_addr),
        .map_bit      (map_bit),
        .min_stripes  (cfg.min_stripes),
        .stripe_count (stripe_count),
        .crossing     (crossing),
        .det_done     (det_done)
    );

    // ==================================================================
    // Control
    // ==================================================================

    apb_regs u_apb_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .cfg          (cfg),
        .capture_cmd  (capture_cmd),
        .clear_cmd    (clear_cmd),
        .stripe_count (stripe_count),
        .crossing     (crossing),
        .det_done     (det_done)
    );

endmodule

// File: src/stripe_detector.sv
module stripe_detector (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          map_full,
    output logic [vision_pkg::map_aw-1:0] map_addr,
    input  logic                          map_bit,
    input  logic [7:0]                    min_stripes,
    output logic [7:0]                    stripe_count,
    output logic                          crossing,
    output logic                          det_done
);
    import vision_pkg::*;
    import ctrl_pkg::*;

    det_state_e       state_q;
    // Row being addressed, one ahead of the returning bit
    logic [row_w-1:0] row_q;
    logic             full_q;
    logic             prev_q;
    logic [7:0]       cnt_q;
    logic [7:0]       cnt_next;
    logic             start;

    // Scan on the rising edge of map_full
    assign start = map_full && !full_q && (state_q == DET_IDLE);

    // Column det_col of the window, row major map
    assign map_addr = map_aw'(row_q * win_w + det_col);

    // A new run starts on every 0 to 1 step
    assign cnt_next = cnt_q + 8'(map_bit && !prev_q);

    // ==================================================================
    // Scan FSM
    // ==================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= DET_IDLE;
            row_q        <= '0;
            full_q       <= 1'b0;
            prev_q       <= 1'b0;
            cnt_q        <= '0;
            stripe_count <= '0;
            crossing     <= 1'b0;
        end else begin
            full_q <= map_full;
            case (state_q)
                DET_IDLE: begin
                    if (start) begin
                        state_q <= DET_ADDR;
                        row_q   <= '0;
                        cnt_q   <= '0;
                        // Bit above row 0 counts as zero
                        prev_q  <= 1'b0;
                    end
                end
                // First read in flight
                DET_ADDR: begin
                    row_q   <= row_q + 1'b1;
                    state_q <= DET_SCAN;
                end
                DET_SCAN: begin
                    row_q  <= row_q + 1'b1;
                    cnt_q  <= cnt_next;
                    prev_q <= map_bit;
                    // Bit of the last row is on map_bit now
                    if (row_q == row_w'(win_h)) begin
                        state_q      <= DET_DONE;
                        stripe_count <= cnt_next;
                        crossing     <= (cnt_next >= min_stripes);
                    end
                end
                default: state_q <= DET_IDLE;
            endcase
        end
    end

    // One cycle result strobe
    assign det_done = (state_q == DET_DONE);

endmodule

// File: src/vision_pkg.sv
package vision_pkg;

    // ==================================================================
    // Frame geometry
    // ==================================================================

    // Raw frame size in pixels
    localparam int img_w = 16;
    localparam int img_h = 12;

    // Valid 3x3 window positions per frame
    localparam int win_w = img_w - 2;
    localparam int win_h = img_h - 2;

    // Edge map depth and address width
    localparam int map_depth = win_w * win_h;
    localparam int map_aw    = 8;

    // Raster counter widths
    localparam int col_w = $clog2(img_w);
    localparam int row_w = $clog2(img_h);

    // Window column scanned by the stripe detector
    localparam int det_col = 7;

    // ==================================================================
    // Pixel and stream types
    // ==================================================================

    typedef logic [7:0]        pix_t;
    typedef logic signed [7:0] coef_t;

    // Nine coefficients, row major, element 0 is top left
    typedef coef_t [8:0] kernel_t;

    // Input beat, sof marks pixel (0,0)
    typedef struct packed {
        pix_t data;
        logic sof;
    } pix_beat_t;

    // Filtered beat, sof marks the first window of a frame
    typedef struct packed {
        pix_t mag;
        logic sof;
    } edge_beat_t;

endpackage

// File: tb/pattern_recognition_assert.sv
module pattern_recognition_assert (
    input logic                   clk,
    input logic                   rst_n,
    input vision_pkg::pix_beat_t  pix_in,
    input logic                   pix_valid,
    input logic                   pix_ready,
    input vision_pkg::edge_beat_t edge_out,
    input logic                   edge_valid,
    input logic                   edge_ready,
    input ctrl_pkg::apb_req_t     apb_req,
    input ctrl_pkg::apb_rsp_t     apb_rsp,
    input logic                   map_full,
    input logic                   det_done
);
    // Failure tally, read by the testbench top
    int unsigned fail_count = 0;

    // ==================================================================
    // Stream handshakes
    // ==================================================================

    // Source holds a stalled input beat
    pix_hold: assert property (@(posedge clk) disable iff (!rst_n)
        pix_valid && !pix_ready |=> pix_valid && $stable(pix_in))
    else begin
        $error("pix_in dropped or changed while stalled");
        fail_count++;
    end

    // Filter holds a stalled output beat
    edge_hold: assert property (@(posedge clk) disable iff (!rst_n)
        edge_valid && !edge_ready |=> edge_valid && $stable(edge_out))
    else begin
        $error("edge_out dropped or changed while stalled");
        fail_count++;
    end

    // ==================================================================
    // Bus and detector timing
    // ==================================================================

    apb_no_wait: assert property (@(posedge clk) disable iff (!rst_n)
        apb_req.psel && apb_req.penable |-> apb_rsp.pready)
    else begin
        $error("pready low in access phase");
        fail_count++;
    end

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        det_done |=> !det_done)
    else begin
        $error("det_done longer than one cycle");
        fail_count++;
    end

    // Result strobe only 12 cycles after map_full rises
    done_delay: assert property (@(posedge clk) disable iff (!rst_n)
        det_done |-> $past(map_full, 12) && !$past(map_full, 13))
    else begin
        $error("det_done not 12 cycles after map_full rose");
        fail_count++;
    end

    // And every rise gets its strobe
    done_follows: assert property (@(posedge clk) disable iff (!rst_n)
        $past(map_full, 12) && !$past(map_full, 13) |-> det_done)
    else begin
        $error("det_done missing 12 cycles after map_full rose");
        fail_count++;
    end

    // Idle outputs right out of reset
    reset_idle: assert property (@(posedge clk)
        $rose(rst_n) |-> pix_ready && !edge_valid && !det_done && !map_full)
    else begin
        $error("outputs not idle after reset");
        fail_count++;
    end

endmodule

bind pattern_recognition pattern_recognition_assert u_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .pix_in     (pix_in),
    .pix_valid  (pix_valid),
    .pix_ready  (pix_ready),
    .edge_out   (edge_out),
    .edge_valid (edge_valid),
    .edge_ready (edge_ready),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .map_full   (map_full),
    .det_done   (det_done)
);

// File: tb/tb_pattern_recognition.sv
module tb_pattern_recognition;
    import vision_pkg::*;
    import ctrl_pkg::*;

    // ==================================================================
    // Run constants
    // ==================================================================

    localparam int period    = 100;
    localparam int seed      = 98;
    localparam int scan_col  = 7;
    localparam int thresh    = 100;
    localparam int n_beats   = 140;
    localparam int n_frames  = 5;
    localparam int frame_len = img_w * img_h;
    // Frames with stalls at up to 4x, plus register traffic and reset
    localparam int limit_cycles = 16 + n_frames * (frame_len * 4 + 64) + 2000;

    logic       clk        = 1'b0;
    logic       rst_n;
    pix_beat_t  pix_in;
    logic       pix_valid;
    logic       pix_ready;
    edge_beat_t edge_out;
    logic       edge_valid;
    logic       edge_ready = 1'b1;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    logic       det_done;

    // Frame under test and model kernel, vertical gradient
    pix_t frame [img_h][img_w];
    int   kern [9] = '{-1, -2, -1, 0, 0, 0, 1, 2, 1};

    // Collected output beats
    pix_t got_mag [$];
    logic got_sof [$];

    logic        stall_en = 1'b0;
    int          done_cnt = 0;
    int          errors   = 0;
    int          tests    = 0;
    int          failed   = 0;
    int          test_err0;
    logic [31:0] rd;
    logic        err;
    logic [31:0] status;

    pattern_recognition u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .pix_in     (pix_in),
        .pix_valid  (pix_valid),
        .pix_ready  (pix_ready),
        .edge_out   (edge_out),
        .edge_valid (edge_valid),
        .edge_ready (edge_ready),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .det_done   (det_done)
    );

    always #(period / 2) clk = ~clk;

    // Random back-pressure, roughly one stall in three
    always @(negedge clk) begin
        edge_ready = stall_en ? (($urandom % 3) != 0) : 1'b1;
    end

    // Output monitor on the stream handshake
    always @(posedge clk) begin
        if (rst_n && edge_valid && edge_ready) begin
            got_mag.push_back(edge_out.mag);
            got_sof.push_back(edge_out.sof);
        end
        if (det_done) begin
            done_cnt++;
        end
    end

    initial begin
        #(limit_cycles * period);
        $display("timeout: run did not finish within %0d cycles", limit_cycles);
        $display("TEST FAIL");
        $finish;
    end

    // ==================================================================
    // Helpers
    // ==================================================================

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic start_test();
        test_err0 = errors;
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_err0) begin
            $display("test %s: passed", name);
        end else begin
            failed++;
            $display("test %s: failed with %0d errors", name, errors - test_err0);
        end
    endtask

    // Setup, then access phase sampled mid cycle
    task automatic apb_xfer(input logic wr, input logic [7:0] addr,
                            input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr);
        @(negedge clk);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(negedge clk);
        apb_req.penable = 1'b1;
        #(period / 4);
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic write_check(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        slverr;
        apb_xfer(1'b1, addr, data, rdata, slverr);
        expect_eq($sformatf("pslverr on write 0x%h", addr), 32'(slverr), 0);
        apb_xfer(1'b0, addr, '0, rdata, slverr);
        expect_eq($sformatf("prdata at 0x%h", addr), rdata, data);
    endtask

    task automatic fill_random();
        for (int r = 0; r < img_h; r++) begin
            for (int c = 0; c < img_w; c++) begin
                frame[r][c] = pix_t'($urandom);
            end
        end
    endtask

    // Bright rows at 200 on a dark 20 background
    task automatic fill_bands(input logic [11:0] rows);
        for (int r = 0; r < img_h; r++) begin
            for (int c = 0; c < img_w; c++) begin
                frame[r][c] = rows[r] ? 8'd200 : 8'd20;
            end
        end
    endtask

    // Raster order, each pixel held until accepted
    task automatic send_frame();
        got_mag.delete();
        got_sof.delete();
        for (int r = 0; r < img_h; r++) begin
            for (int c = 0; c < img_w; c++) begin
                @(negedge clk);
                pix_valid = 1'b1;
                pix_in    = '{data: frame[r][c], sof: (r == 0 && c == 0)};
                #(period / 4);
                while (!pix_ready) begin
                    @(negedge clk);
                    #(period / 4);
                end
            end
        end
        @(negedge clk);
        pix_valid = 1'b0;
    endtask

    task automatic wait_beats();
        while (got_mag.size() < n_beats) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        expect_eq("output beat count", got_mag.size(), n_beats);
    endtask

    // Reference filter for the window ending at pixel (r, c)
    function automatic int window_mag(input int r, input int c);
        int sum;
        sum = 0;
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                sum += kern[3 * i + j] * int'(frame[r - 2 + i][c - 2 + j]);
            end
        end
        if (sum < 0) begin
            sum = -sum;
        end
        return (sum > 255) ? 255 : sum;
    endfunction

    // Runs of edge bits down the scanned window column
    function automatic int column_runs();
        int   runs;
        logic prev;
        logic bit_now;
        runs = 0;
        prev = 1'b0;
        for (int wr = 0; wr < win_h; wr++) begin
            bit_now = (window_mag(wr + 2, scan_col + 2) >= thresh);
            if (bit_now && !prev) begin
                runs++;
            end
            prev = bit_now;
        end
        return runs;
    endfunction

    task automatic capture_frame(output logic [31:0] result);
        int          done0;
        logic [31:0] rdata;
        logic        slverr;
        done0 = done_cnt;
        apb_xfer(1'b1, CMD, 32'(CAPTURE), rdata, slverr);
        send_frame();
        while (done_cnt == done0) begin
            @(posedge clk);
        end
        apb_xfer(1'b0, STATUS, '0, result, slverr);
    endtask

    task automatic check_result(input logic [31:0] result, input int min_count);
        int runs;
        runs = column_runs();
        expect_eq("status.done", 32'(result[0]), 1);
        expect_eq("status.crossing", 32'(result[1]), 32'(runs >= min_count));
        expect_eq("status.stripe_count", 32'(result[15:8]), runs);
    endtask

    // ==================================================================
    // Test sequence
    // ==================================================================

    initial begin
        void'($urandom(seed));
        rst_n     = 1'b0;
        pix_valid = 1'b0;
        pix_in    = '0;
        apb_req   = '0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        start_test();
        apb_xfer(1'b0, MIN_STRIPES, '0, rd, err);
        expect_eq("min_stripes after reset", rd, 32'd3);
        write_check(KERN0, 32'h00FFFEFF);
        write_check(KERN1, 32'h005AA53C);
        write_check(KERN1, 32'h00000000);
        write_check(KERN2, 32'h00010201);
        write_check(THRESH, 32'h000000A5);
        write_check(THRESH, 32'(thresh));
        write_check(MIN_STRIPES, 32'h0000005A);
        write_check(MIN_STRIPES, 32'd3);
        apb_xfer(1'b1, STATUS, 32'd1, rd, err);
        expect_eq("pslverr on STATUS write", 32'(err), 1);
        apb_xfer(1'b0, 8'h20, '0, rd, err);
        expect_eq("pslverr on unmapped read", 32'(err), 1);
        end_test("register access");

        start_test();
        fill_random();
        send_frame();
        wait_beats();
        for (int i = 0; i < n_beats; i++) begin
            expect_eq($sformatf("edge_out.mag[%0d]", i), 32'(got_mag[i]),
                      window_mag(i / win_w + 2, i % win_w + 2));
            expect_eq($sformatf("edge_out.sof[%0d]", i), 32'(got_sof[i]), 32'(i == 0));
        end
        end_test("filtering");

        // Same frame again, now with stalls on the output
        start_test();
        stall_en = 1'b1;
        send_frame();
        wait_beats();
        stall_en = 1'b0;
        for (int i = 0; i < n_beats; i++) begin
            expect_eq($sformatf("edge_out.mag[%0d]", i), 32'(got_mag[i]),
                      window_mag(i / win_w + 2, i % win_w + 2));
            expect_eq($sformatf("edge_out.sof[%0d]", i), 32'(got_sof[i]), 32'(i == 0));
        end
        end_test("back-pressure");

        // Bright rows 1, 4, 7 and 10
        start_test();
        fill_bands(12'h492);
        stall_en = 1'b1;
        capture_frame(status);
        stall_en = 1'b0;
        check_result(status, 3);
        end_test("crossing detected");

        start_test();
        apb_xfer(1'b1, CMD, 32'(CLEAR), rd, err);
        apb_xfer(1'b0, STATUS, '0, rd, err);
        expect_eq("status.done after clear", 32'(rd[0]), 0);
        // One band over rows 5 and 6
        fill_bands(12'h060);
        capture_frame(status);
        check_result(status, 3);
        apb_xfer(1'b1, CMD, 32'(CLEAR), rd, err);
        write_check(MIN_STRIPES, 32'd8);
        fill_bands(12'h492);
        capture_frame(status);
        check_result(status, 8);
        end_test("no crossing");

        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests, failed, errors, u_dut.u_assert.fail_count);
        if (errors == 0 && u_dut.u_assert.fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
